/* source/keypad_pkg.sv */
// Keypad shared definitions
package keypad_pkg;

	// poller timing, scaled down for simulation
	localparam int CNT_W = 7;                                          // tick counter width
	localparam logic [CNT_W-1:0] TICKS_DEBOUNCE = 7'd100;             // settle time after column change
	localparam logic [CNT_W-1:0] TICKS_HOLD = 7'd20;                  // spacing of confirming samples

	// key queue geometry
	localparam int FIFO_AW = 3;                                        // pointer width
	localparam logic [FIFO_AW:0] FIFO_DEPTH = 4'd8;                   // entries, 2**FIFO_AW

	// scan and confirm sequence of the poller
	typedef enum logic [2:0] {
		st_init,
		st_shift_column,
		st_wait_debounce,
		st_check_row1,
		st_keypress_hold,
		st_check_row2
	} poll_state_e;

	// key codes, digits map to their own value
	typedef enum logic [3:0] {
		key_0, key_1, key_2, key_3, key_4,
		key_5, key_6, key_7, key_8, key_9,
		key_a, key_b, key_c, key_d,
		key_star,                                                      // 14
		key_hash                                                       // 15
	} key_code_e;

	// one detected contact, column and rows as seen on the pins
	typedef struct packed {
		logic [3:0] col;                                               // one-hot active column
		logic [3:0] row;                                               // raw row pattern
	} key_hit_t;

endpackage

/* source/keypad_poller.sv */
// Keypad column scanner
`timescale 1ns/10ps

module keypad_poller (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [3:0]           keypad_row_in,  // rows, synchronized on the board
	output logic [3:0]           keypad_col_out, // one-hot column drive
	output keypad_pkg::key_hit_t hit,            // latched column/row of the last contact
	output logic                 press,          // one pulse per new confirmed press
	output logic                 key_held        // level while the key stays confirmed
);

	keypad_pkg::poll_state_e state;
	logic [keypad_pkg::CNT_W-1:0] tick_cnt; // shared debounce and hold counter
	logic row_active;

	assign row_active = (keypad_row_in != 4'b0000); // any row answering

	// control path
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state          <= keypad_pkg::st_init;
			keypad_col_out <= 4'b0001;
			tick_cnt       <= '0;
			press          <= 1'b0;
			key_held       <= 1'b0;
		end
		else
		begin
			press <= 1'b0; // strobe by default
			case (state)
				keypad_pkg::st_init:
				begin
					key_held <= 1'b0;
					state    <= keypad_pkg::st_shift_column;
				end
				keypad_pkg::st_shift_column:
				begin
					keypad_col_out <= {keypad_col_out[2:0], keypad_col_out[3]}; // rotate left
					tick_cnt       <= '0;
					state          <= keypad_pkg::st_wait_debounce;
				end
				keypad_pkg::st_wait_debounce:
				begin
					tick_cnt <= tick_cnt + 1'b1;
					if (tick_cnt == keypad_pkg::TICKS_DEBOUNCE) // TICKS_DEBOUNCE+1 cycles here
						state <= keypad_pkg::st_check_row1;
				end
				keypad_pkg::st_check_row1:
				begin
					if (row_active)
					begin
						tick_cnt <= '0;
						state    <= keypad_pkg::st_keypress_hold; // hit latched below
					end
					else
						state <= keypad_pkg::st_shift_column; // nothing here, next column
				end
				keypad_pkg::st_keypress_hold:
				begin
					tick_cnt <= tick_cnt + 1'b1;
					if (tick_cnt == keypad_pkg::TICKS_HOLD)
						state <= keypad_pkg::st_check_row2;
				end
				keypad_pkg::st_check_row2:
				begin
					if (row_active)
					begin
						// still down, column stays put and we confirm again later
						press    <= !key_held; // only the first confirmation counts
						key_held <= 1'b1;
						tick_cnt <= '0;
						state    <= keypad_pkg::st_keypress_hold;
					end
					else
					begin
						key_held <= 1'b0; // released
						state    <= keypad_pkg::st_init;
					end
				end
				default:
					state <= keypad_pkg::st_init;
			endcase
		end
	end

	// capture of the contact, read only together with press
	always_ff @(posedge clk)
	begin
		if (state == keypad_pkg::st_check_row1 && row_active)
		begin
			hit.col <= keypad_col_out;
			hit.row <= keypad_row_in;
		end
	end

endmodule

/* source/key_encoder.sv */
// Key code encoder
`timescale 1ns/10ps

module key_encoder (
	input  logic                  clk,
	input  logic                  rst_n,
	input  keypad_pkg::key_hit_t  hit,   // column/row from the poller
	input  logic                  press, // hit is valid now
	output keypad_pkg::key_code_e code,  // code of the last clean press
	output logic                  push,  // write code into the queue
	output logic                  ghost  // several rows in one column
);

	logic multi_row;

	// one-hot nibble to index, only meaningful with a single bit set
	function automatic logic [1:0] onehot_idx(input logic [3:0] v);
		onehot_idx = {v[3] | v[2], v[3] | v[1]};
	endfunction

	// layout: row 0 top, column 0 left
	function automatic keypad_pkg::key_code_e key_at(input logic [1:0] r, input logic [1:0] c);
		case ({r, c})
			4'h0: key_at = keypad_pkg::key_1;
			4'h1: key_at = keypad_pkg::key_2;
			4'h2: key_at = keypad_pkg::key_3;
			4'h3: key_at = keypad_pkg::key_a;
			4'h4: key_at = keypad_pkg::key_4;
			4'h5: key_at = keypad_pkg::key_5;
			4'h6: key_at = keypad_pkg::key_6;
			4'h7: key_at = keypad_pkg::key_b;
			4'h8: key_at = keypad_pkg::key_7;
			4'h9: key_at = keypad_pkg::key_8;
			4'ha: key_at = keypad_pkg::key_9;
			4'hb: key_at = keypad_pkg::key_c;
			4'hc: key_at = keypad_pkg::key_star;
			4'hd: key_at = keypad_pkg::key_0;
			4'he: key_at = keypad_pkg::key_hash;
			4'hf: key_at = keypad_pkg::key_d;
		endcase
	endfunction

	// clearing the lowest set bit leaves something only if two or more were set
	assign multi_row = ((hit.row & (hit.row - 4'd1)) != 4'd0);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			push  <= 1'b0;
			ghost <= 1'b0;
		end
		else
		begin
			push  <= press && !multi_row;
			ghost <= press && multi_row; // reported, never queued
		end
	end

	always_ff @(posedge clk)
	begin
		if (press)
			code <= key_at(onehot_idx(hit.row), onehot_idx(hit.col));
	end

endmodule

/* source/key_fifo.sv */
// Key code queue
`timescale 1ns/10ps

module key_fifo (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       push,      // write strobe
	input  keypad_pkg::key_code_e      code_in,
	input  logic                       pop,       // host read strobe
	output keypad_pkg::key_code_e      code_out,  // head of queue
	output logic                       not_empty,
	output logic [keypad_pkg::FIFO_AW:0] count,   // entries held
	output logic                       overflow   // sticky, a push was lost
);

	keypad_pkg::key_code_e mem [0:keypad_pkg::FIFO_DEPTH-1];
	logic [keypad_pkg::FIFO_AW-1:0] wr_ptr;
	logic [keypad_pkg::FIFO_AW-1:0] rd_ptr;
	logic full;
	logic do_push;
	logic do_pop;

	assign full      = (count == keypad_pkg::FIFO_DEPTH);
	assign not_empty = (count != '0);
	assign do_push   = push && !full;      // dropped when full
	assign do_pop    = pop && not_empty;   // empty pop ignored
	assign code_out  = mem[rd_ptr];

	// storage
	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= code_in;
	end

	// pointers, occupancy and overflow
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // none, or both at once
			endcase
			if (push && full)
				overflow <= 1'b1;
		end
	end

endmodule

/* source/keypad_top.sv */
// Keypad front end top level
`timescale 1ns/10ps

module keypad_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [3:0]            keypad_row_in,
	input  logic                  pop,            // host pops the head
	output logic [3:0]            keypad_col_out,
	output keypad_pkg::key_code_e key_code,       // queue head
	output logic                  key_ready,      // queue not empty
	output logic [3:0]            key_count,
	output logic                  overflow,
	output logic                  ghost,
	output logic                  key_held
);

	keypad_pkg::key_hit_t  hit;
	keypad_pkg::key_code_e enc_code;
	logic press;
	logic push;

	// scan, debounce, confirm
	keypad_poller u_poller (
		.clk            (clk),
		.rst_n          (rst_n),
		.keypad_row_in  (keypad_row_in),
		.keypad_col_out (keypad_col_out),
		.hit            (hit),
		.press          (press),
		.key_held       (key_held)
	);

	// contact to code, ghost filter
	key_encoder u_encoder (
		.clk   (clk),
		.rst_n (rst_n),
		.hit   (hit),
		.press (press),
		.code  (enc_code),
		.push  (push),
		.ghost (ghost)
	);

	key_fifo u_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (push),
		.code_in   (enc_code),
		.pop       (pop),
		.code_out  (key_code),
		.not_empty (key_ready),
		.count     (key_count),
		.overflow  (overflow)
	);

endmodule

/* verif/keypad_chk.sv */
// Keypad front end assertions
`timescale 1ns/10ps

module keypad_chk (
	input logic       clk,
	input logic       rst_n,
	input logic [3:0] keypad_col_out,
	input logic       press,
	input logic       ghost,
	input logic [3:0] key_count,
	input logic       overflow
);

	int col_fails = 0;
	int press_fails = 0;
	int ghost_fails = 0;
	int count_fails = 0;
	int ovf_fails = 0;
	int fails; // read by the testbench at the end

	assign fails = col_fails + press_fails + ghost_fails + count_fails + ovf_fails;

	col_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(keypad_col_out))
	else
	begin
		$error("keypad_col_out is not one-hot: %b", keypad_col_out);
		col_fails = col_fails + 1;
	end

	press_pulse: assert property (@(posedge clk) disable iff (!rst_n) press |=> !press)
	else
	begin
		$error("press held longer than one cycle");
		press_fails = press_fails + 1;
	end

	ghost_pulse: assert property (@(posedge clk) disable iff (!rst_n) ghost |=> !ghost)
	else
	begin
		$error("ghost held longer than one cycle");
		ghost_fails = ghost_fails + 1;
	end

	count_range: assert property (@(posedge clk) disable iff (!rst_n)
		key_count <= keypad_pkg::FIFO_DEPTH)
	else
	begin
		$error("key_count above queue depth: %0d", key_count);
		count_fails = count_fails + 1;
	end

	// sticky until reset
	ovf_sticky: assert property (@(posedge clk) disable iff (!rst_n) !$fell(overflow))
	else
	begin
		$error("overflow cleared without reset");
		ovf_fails = ovf_fails + 1;
	end

endmodule

bind keypad_top keypad_chk u_keypad_chk (
	.clk            (clk),
	.rst_n          (rst_n),
	.keypad_col_out (keypad_col_out),
	.press          (press),
	.ghost          (ghost),
	.key_count      (key_count),
	.overflow       (overflow)
);

/* verif/tb_keypad.sv */
// Keypad front end testbench
`timescale 1ns/10ps

module tb_keypad;

	logic                  clk;
	logic                  rst_n;
	logic [3:0]            keypad_row_in;
	logic                  pop;
	logic [3:0]            keypad_col_out;
	keypad_pkg::key_code_e key_code;
	logic                  key_ready;
	logic [3:0]            key_count;
	logic                  overflow;
	logic                  ghost;
	logic                  key_held;

	logic [15:0] pressed;          // key matrix, bit index is row*4 + col
	logic [16:0] lfsr;             // stimulus jitter source
	int ghost_cnt = 0;             // ghost pulses seen so far
	int release_cycles;
	int limit_cycles = 0;          // watchdog arms once this is set
	keypad_pkg::key_code_e layout [0:15];

	// one entry per pattern line
	logic [7:0] op_q [$];
	int k1_q [$];
	int k2_q [$];
	int hold_q [$];
	int cnt_q [$];
	int ovf_q [$];
	int gh_q [$];

	keypad_top DUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.keypad_row_in  (keypad_row_in),
		.pop            (pop),
		.keypad_col_out (keypad_col_out),
		.key_code       (key_code),
		.key_ready      (key_ready),
		.key_count      (key_count),
		.overflow       (overflow),
		.ghost          (ghost),
		.key_held       (key_held)
	);

	always #4 clk = ~clk;

	// matrix model, a row answers when a pressed key sits in the driven column
	always_comb
	begin
		for (int r = 0; r < 4; r++)
			keypad_row_in[r] = |(pressed[r*4 +: 4] & keypad_col_out);
	end

	always @(negedge clk)
	begin
		if (ghost)
			ghost_cnt <= ghost_cnt + 1;
	end

	// x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_step(input logic [16:0] s);
		lfsr_step = {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic random_extra(output int extra);
		extra = 0;
		for (int b = 0; b < 4; b++) // 0..15 cycles
		begin
			lfsr  = lfsr_step(lfsr);
			extra = extra * 2 + int'(lfsr[0]);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_code(input string name, input keypad_pkg::key_code_e got,
		input keypad_pkg::key_code_e exp);
		if (got !== exp)
			abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_count(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp)
			abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic load_patterns;
		int fd;
		int n;
		int k1, k2, hold, cnt, ovf, gh;
		int scan_max;
		int total;
		logic [7:0] op;
		logic [8*128-1:0] rest;
		// worst case until key_held, full scan plus one hold period
		scan_max = 4 * (int'(keypad_pkg::TICKS_DEBOUNCE) + 3)
			+ 2 * (int'(keypad_pkg::TICKS_HOLD) + 2);
		total    = 1016;
		fd = $fopen("verif/keypad_patterns.txt", "r");
		if (fd == 0)
			abort_run("could not open verif/keypad_patterns.txt for reading");
		while ($fscanf(fd, "%s", op) == 1)
		begin
			if (op == "#")
				n = $fgets(rest, fd); // comment line
			else
			begin
				n = $fscanf(fd, "%d %d %d %d %d %d", k1, k2, hold, cnt, ovf, gh);
				if (n != 6)
					abort_run($sformatf("pattern line %0d is incomplete", op_q.size() + 1));
				op_q.push_back(op);
				k1_q.push_back(k1);
				k2_q.push_back(k2);
				hold_q.push_back(hold);
				cnt_q.push_back(cnt);
				ovf_q.push_back(ovf);
				gh_q.push_back(gh);
				total += hold + 16 + release_cycles + scan_max;
			end
		end
		$fclose(fd);
		limit_cycles = total;
	endtask

	// hold keys, optionally counted from the confirmation, then release
	task automatic press_keys(input logic [15:0] keys, input int hold, input bit wait_confirm);
		@(posedge clk);
		pressed <= keys;
		if (wait_confirm)
		begin
			@(negedge clk);
			while (!key_held)
				@(negedge clk);
		end
		repeat (hold) @(posedge clk);
		pressed <= '0;
		repeat (release_cycles) @(posedge clk); // let the scanner settle
	endtask

	// short contact centred on the first row sample of its column
	task automatic press_short(input logic [15:0] keys, input logic [3:0] col, input int hold);
		@(negedge clk);
		while (keypad_col_out == col)
			@(negedge clk);
		while (keypad_col_out != col)
			@(negedge clk);
		// rows are sampled TICKS_DEBOUNCE+2 edges after the column moves
		repeat (int'(keypad_pkg::TICKS_DEBOUNCE) - 5) @(posedge clk);
		press_keys(keys, hold, 1'b0);
	endtask

	task automatic pop_head(input int key, input bit expect_empty);
		@(negedge clk);
		if (expect_empty)
			check_flag("key_ready", key_ready, 1'b0);
		else
		begin
			check_flag("key_ready", key_ready, 1'b1);
			check_code("key_code", key_code, layout[key]); // tb's own layout
		end
		@(posedge clk);
		pop <= 1'b1;
		@(posedge clk);
		pop <= 1'b0;
	endtask

	initial
	begin
		int g0;
		int extra;
		logic [15:0] keys;
		clk     = 1'b0;
		rst_n   = 1'b0;
		pop     = 1'b0;
		pressed = '0;
		lfsr    = 17'd88104;
		release_cycles = 2 * (int'(keypad_pkg::TICKS_DEBOUNCE) + int'(keypad_pkg::TICKS_HOLD));
		// row 0 top, column 0 left
		layout = '{
			keypad_pkg::key_1, keypad_pkg::key_2, keypad_pkg::key_3, keypad_pkg::key_a,
			keypad_pkg::key_4, keypad_pkg::key_5, keypad_pkg::key_6, keypad_pkg::key_b,
			keypad_pkg::key_7, keypad_pkg::key_8, keypad_pkg::key_9, keypad_pkg::key_c,
			keypad_pkg::key_star, keypad_pkg::key_0, keypad_pkg::key_hash, keypad_pkg::key_d
		};
		load_patterns();
		repeat (15) @(posedge clk);
		@(negedge clk);
		check_count("keypad_col_out", keypad_col_out, 4'b0001); // state in reset
		check_flag("key_held", key_held, 1'b0);
		check_flag("ghost", ghost, 1'b0);
		@(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < op_q.size(); i++)
		begin
			g0   = ghost_cnt;
			keys = 16'(1 << k1_q[i]) | 16'(1 << k2_q[i]); // k2 equals k1 for one key
			case (op_q[i])
				"P", "G":
				begin
					random_extra(extra);
					press_keys(keys, hold_q[i] + extra, 1'b1);
				end
				"S": press_short(keys, 4'(1 << (k1_q[i] % 4)), hold_q[i]); // gone by 2nd sample
				"O": pop_head(k1_q[i], 1'b0);
				"E": pop_head(k1_q[i], 1'b1);
				"C": ;
				default: abort_run($sformatf("unknown operation in pattern line %0d", i + 1));
			endcase
			@(negedge clk);
			check_count("key_count", key_count, 4'(cnt_q[i]));
			check_flag("overflow", overflow, 1'(ovf_q[i]));
			check_flag("ghost", ghost_cnt != g0, 1'(gh_q[i]));
			check_flag("key_ready", key_ready, cnt_q[i] != 0);
			check_flag("key_held", key_held, 1'b0); // all keys up by now
		end
		if (DUT.u_keypad_chk.fails == 0)
		begin
			$display("TB PASSED");
			$finish;
		end
		else
			abort_run("the bound checker reported assertion failures");
	end

	// watchdog
	initial
	begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		abort_run($sformatf("timeout, the test did not end within %0d cycles", limit_cycles));
	end

endmodule

/* verif/keypad_patterns.txt */
# op k1 k2 hold count overflow ghost, key index is row*4 + col
# P press  G two-key press  S short press  O pop with k1 at head  E empty pop  C check
C 0 0 0 0 0 0
P 0 0 60 1 0 0
P 0 0 200 2 0 0
S 5 5 10 2 0 0
G 3 7 60 2 0 1
O 0 0 0 1 0 0
O 0 0 0 0 0 0
P 1 1 600 1 0 0
P 2 2 60 2 0 0
P 3 3 60 3 0 0
P 4 4 60 4 0 0
P 5 5 60 5 0 0
P 6 6 60 6 0 0
P 7 7 60 7 0 0
O 1 0 0 6 0 0
O 2 0 0 5 0 0
O 3 0 0 4 0 0
O 4 0 0 3 0 0
O 5 0 0 2 0 0
O 6 0 0 1 0 0
O 7 0 0 0 0 0
P 8 8 60 1 0 0
P 9 9 60 2 0 0
P 10 10 60 3 0 0
P 11 11 60 4 0 0
P 12 12 60 5 0 0
P 13 13 60 6 0 0
P 14 14 60 7 0 0
P 15 15 60 8 0 0
P 0 0 60 8 1 0
O 8 0 0 7 1 0
O 9 0 0 6 1 0
O 10 0 0 5 1 0
O 11 0 0 4 1 0
O 12 0 0 3 1 0
O 13 0 0 2 1 0
O 14 0 0 1 1 0
O 15 0 0 0 1 0
E 0 0 0 0 1 0

/* list.f */
source/keypad_pkg.sv
source/keypad_poller.sv
source/key_encoder.sv
source/key_fifo.sv
source/keypad_top.sv
verif/keypad_chk.sv
verif/tb_keypad.sv

/* run.sh */
#!/bin/sh
# build and run the keypad testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_keypad -f list.f -o tb_keypad_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/tb_keypad_sim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
else
	echo "pass message not found"
	exit 1
fi
